// ==== rtl/arcade_io_pkg.sv ====
package arcade_io_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int RGB_W    = 6;   // bits per VGA colour channel.
	localparam int STATUS_W = 32;  // menu status word.

	// bit positions in the menu status word.
	localparam int STATUS_RESET_BIT      = 0;
	localparam int STATUS_TEST_BIT       = 1;
	localparam int STATUS_MENU_RESET_BIT = 6;

	////////////////////
	// PS/2 set 2 scan codes
	////////////////////

	localparam logic [7:0] SC_BREAK = 8'hF0;
	localparam logic [7:0] SC_EXT   = 8'hE0;
	localparam logic [7:0] SC_UP    = 8'h75;  // after E0.
	localparam logic [7:0] SC_DOWN  = 8'h72;  // after E0.
	localparam logic [7:0] SC_LEFT  = 8'h6B;  // after E0.
	localparam logic [7:0] SC_RIGHT = 8'h74;  // after E0.
	localparam logic [7:0] SC_SPACE = 8'h29;
	localparam logic [7:0] SC_1     = 8'h16;
	localparam logic [7:0] SC_2     = 8'h1E;
	localparam logic [7:0] SC_5     = 8'h2E;

	////////////////////
	// shared types
	////////////////////

	// active high with right in bit 0 as on the MiST joystick word.
	typedef struct packed {
		logic coin;
		logic start2;
		logic start1;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic [7:0] data;
		logic       parity_ok;  // clear on a parity or stop bit error.
	} scan_t;

	// game inputs are all active low.
	typedef struct packed {
		logic up_n;
		logic down_n;
		logic left_n;
		logic right_n;
		logic fire_n;
		logic start1_n;
		logic start2_n;
		logic coin_n;
		logic test_n;
	} controls_t;

	typedef struct packed {
		logic pixel;
		logic hs;
		logic vs;
		logic hb;
		logic vb;
	} video_in_t;

	typedef struct packed {
		logic [RGB_W-1:0] r;
		logic [RGB_W-1:0] g;
		logic [RGB_W-1:0] b;
	} rgb_t;

endpackage

// ==== rtl/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 ps2_clk,
	input  logic                 ps2_data,
	output arcade_io_pkg::scan_t scan,
	output logic                 scan_valid
);

	import arcade_io_pkg::*;

	localparam logic [3:0] PARITY_BIT = 4'd9;
	localparam logic [3:0] STOP_BIT   = 4'd10;

	logic [SYNC_STAGES-1:0] clk_sync;
	logic [SYNC_STAGES-1:0] data_sync;
	logic                   clk_prev;
	logic                   fall_q;
	logic                   bit_q;
	logic [3:0]             bit_cnt;
	logic [7:0]             shift_reg;
	logic                   parity_bit;
	logic [11:0]            stall_cnt;
	scan_t                  scan_next;

	////////////////////
	// pin synchronizer
	////////////////////

	// both lines idle high, so the chain starts high and shows no false edge.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
			fall_q    <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_sync[SYNC_STAGES-1];
			fall_q    <= clk_prev & ~clk_sync[SYNC_STAGES-1];  // registered falling edge.
		end
	end

	// data is delayed alongside the edge strobe.
	always_ff @(posedge clk_sys) begin
		bit_q <= data_sync[SYNC_STAGES-1];
	end

	////////////////////
	// frame assembly
	////////////////////

	always_comb begin
		scan_next.data      = shift_reg;
		scan_next.parity_ok = (^{shift_reg, parity_bit}) & bit_q;  // odd parity and stop high.
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			stall_cnt  <= '0;
			scan_valid <= 1'b0;
		end else begin
			scan_valid <= 1'b0;
			if (fall_q) begin
				stall_cnt <= '0;
				if (bit_cnt == 4'd0) begin
					if (!bit_q) begin
						bit_cnt <= 4'd1;  // start bit seen.
					end
				end else if (bit_cnt == STOP_BIT) begin
					bit_cnt    <= 4'd0;
					scan_valid <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != 4'd0) begin
				// a keyboard unplugged mid frame must not hang the receiver.
				if (&stall_cnt) begin
					bit_cnt   <= 4'd0;
					stall_cnt <= '0;
				end else begin
					stall_cnt <= stall_cnt + 12'd1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fall_q) begin
			if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
				shift_reg <= {bit_q, shift_reg[7:1]};  // LSB arrives first.
			end
			if (bit_cnt == PARITY_BIT) begin
				parity_bit <= bit_q;
			end
			if (bit_cnt == STOP_BIT) begin
				scan <= scan_next;
			end
		end
	end

endmodule

// ==== rtl/key_mapper.sv ====
`timescale 1ns/1ps

module key_mapper (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  arcade_io_pkg::scan_t scan,
	input  logic                 scan_valid,
	output arcade_io_pkg::joy_t  keys
);

	import arcade_io_pkg::*;

	logic break_pending;
	logic ext_pending;
	joy_t hit;

	////////////////////
	// code lookup
	////////////////////

	// arrows live behind E0. The same codes without it are keypad keys.
	always_comb begin
		hit = '0;
		if (ext_pending) begin
			hit.up    = (scan.data == SC_UP);
			hit.down  = (scan.data == SC_DOWN);
			hit.left  = (scan.data == SC_LEFT);
			hit.right = (scan.data == SC_RIGHT);
		end else begin
			hit.fire   = (scan.data == SC_SPACE);
			hit.start1 = (scan.data == SC_1);
			hit.start2 = (scan.data == SC_2);
			hit.coin   = (scan.data == SC_5);
		end
	end

	////////////////////
	// held key state
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			keys          <= '0;
			break_pending <= 1'b0;
			ext_pending   <= 1'b0;
		end else if (scan_valid) begin
			if (!scan.parity_ok) begin
				// a damaged byte cannot be trusted to belong to the prefix.
				break_pending <= 1'b0;
				ext_pending   <= 1'b0;
			end else if (scan.data == SC_BREAK) begin
				break_pending <= 1'b1;  // E0 F0 xx keeps the extended flag.
			end else if (scan.data == SC_EXT) begin
				ext_pending <= 1'b1;
			end else begin
				if (break_pending) begin
					keys <= keys & ~hit;
				end else begin
					keys <= keys | hit;
				end
				break_pending <= 1'b0;
				ext_pending   <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/control_merge.sv ====
`timescale 1ns/1ps

module control_merge (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  arcade_io_pkg::joy_t                  keys,
	input  arcade_io_pkg::joy_t                  joystick_0,
	input  arcade_io_pkg::joy_t                  joystick_1,
	input  logic [arcade_io_pkg::STATUS_W-1:0]   status,
	input  logic                                 button_reset,
	output arcade_io_pkg::controls_t             controls,
	output logic                                 game_reset_n
);

	import arcade_io_pkg::*;

	joy_t pressed;
	logic reset_req;
	logic out_of_reset;

	// any source pressing a control activates it.
	assign pressed = keys | joystick_0 | joystick_1;

	assign reset_req = status[STATUS_RESET_BIT] | status[STATUS_MENU_RESET_BIT] | button_reset;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			controls     <= '1;  // every input released.
			out_of_reset <= 1'b0;
			game_reset_n <= 1'b0;
		end else begin
			controls.up_n     <= ~pressed.up;
			controls.down_n   <= ~pressed.down;
			controls.left_n   <= ~pressed.left;
			controls.right_n  <= ~pressed.right;
			controls.fire_n   <= ~pressed.fire;
			controls.start1_n <= ~pressed.start1;
			controls.start2_n <= ~pressed.start2;
			controls.coin_n   <= ~pressed.coin;
			controls.test_n   <= ~status[STATUS_TEST_BIT];
			out_of_reset      <= 1'b1;
			// the game core is held one more cycle so its inputs settle first.
			game_reset_n <= out_of_reset & ~reset_req;
		end
	end

endmodule

// ==== rtl/audio_dac.sv ====
`timescale 1ns/1ps

module audio_dac #(
	parameter int AUDIO_W = 8
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic [AUDIO_W-1:0] sample,
	output logic               audio_bit
);

	////////////////////
	// sigma-delta loop
	////////////////////

	// the top bit is the carry out of the last add.
	logic [AUDIO_W:0] acc;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= {1'b0, acc[AUDIO_W-1:0]} + {1'b0, sample};  // carry is dropped here.
			audio_bit <= acc[AUDIO_W];
		end
	end

	// a full scale sample gives (2**AUDIO_W - 1) ones in every 2**AUDIO_W cycles.

endmodule

// ==== rtl/mono_video_out.sv ====
`timescale 1ns/1ps

module mono_video_out (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_io_pkg::video_in_t video,
	output arcade_io_pkg::rgb_t      rgb,
	output logic                     vga_hs,
	output logic                     vga_vs
);

	import arcade_io_pkg::*;

	logic blank_n;
	logic grey;

	assign blank_n = ~(video.hb | video.vb);
	assign grey    = video.pixel & blank_n;  // black outside the active area.

	////////////////////
	// output register
	////////////////////

	// sync shares the pixel register so both reach the monitor together.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rgb    <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			rgb.r  <= {RGB_W{grey}};
			rgb.g  <= {RGB_W{grey}};
			rgb.b  <= {RGB_W{grey}};
			vga_hs <= video.hs;
			vga_vs <= video.vs;
		end
	end

endmodule

// ==== rtl/arcade_io_top.sv ====
`timescale 1ns/1ps

module arcade_io_top #(
	parameter int AUDIO_W     = 8,
	parameter int SYNC_STAGES = 2
) (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	input  logic                               ps2_clk,
	input  logic                               ps2_data,
	input  arcade_io_pkg::joy_t                joystick_0,
	input  arcade_io_pkg::joy_t                joystick_1,
	input  logic [arcade_io_pkg::STATUS_W-1:0] status,
	input  logic                               button_reset,
	input  logic [AUDIO_W-1:0]                 sample,
	input  arcade_io_pkg::video_in_t           video,
	output arcade_io_pkg::controls_t           controls,
	output logic                               game_reset_n,
	output logic                               audio_bit,
	output arcade_io_pkg::rgb_t                rgb,
	output logic                               vga_hs,
	output logic                               vga_vs
);

	import arcade_io_pkg::*;

	scan_t scan;
	logic  scan_valid;
	joy_t  keys;

	////////////////////
	// control pipeline
	////////////////////

	ps2_receiver #(
		.SYNC_STAGES (SYNC_STAGES)
	) ps2_receiver_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.scan       (scan),
		.scan_valid (scan_valid)
	);

	key_mapper key_mapper_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.scan       (scan),
		.scan_valid (scan_valid),
		.keys       (keys)
	);

	control_merge control_merge_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.keys         (keys),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.button_reset (button_reset),
		.controls     (controls),
		.game_reset_n (game_reset_n)
	);

	////////////////////
	// audio and video
	////////////////////

	audio_dac #(
		.AUDIO_W (AUDIO_W)
	) audio_dac_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sample    (sample),
		.audio_bit (audio_bit)
	);

	mono_video_out mono_video_out_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.video   (video),
		.rgb     (rgb),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

endmodule

// ==== verif/arcade_io_tb.sv ====
`timescale 1ns/1ps

module arcade_io_tb;

	import arcade_io_pkg::*;

	localparam int PS2_HALF     = 20;                   // system cycles per PS/2 half period.
	localparam int FRAME_CYCLES = 12 * 2 * PS2_HALF;    // eleven bits plus an idle gap.
	localparam int SETTLE       = 64;
	localparam int STEP_COUNT   = 21;
	localparam int AUDIO_RUNS   = 5;
	localparam int AUDIO_HOLD   = 512;
	localparam int AUDIO_WINDOW = 256;
	// worst case of three frames per step, then audio, video and some margin.
	localparam int TIMEOUT_CYCLES = 16 + STEP_COUNT * (3 * FRAME_CYCLES + SETTLE)
		+ AUDIO_RUNS * AUDIO_HOLD + 64 + 1000;

	localparam joy_t K_R  = 8'h01;
	localparam joy_t K_L  = 8'h02;
	localparam joy_t K_D  = 8'h04;
	localparam joy_t K_U  = 8'h08;
	localparam joy_t K_F  = 8'h10;
	localparam joy_t K_S1 = 8'h20;
	localparam joy_t K_S2 = 8'h40;
	localparam joy_t K_C  = 8'h80;

	typedef struct packed {
		logic [1:0]  n;         // bytes sent in this step.
		logic [2:0]  bad;       // one flag per byte for a broken parity bit.
		logic [23:0] bytes;     // first byte in the low bits.
		joy_t        keys_exp;  // keys held after the bytes.
		joy_t        j0;
		joy_t        j1;
		logic [31:0] status;
		logic        btn;
	} step_t;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        ps2_clk;
	logic        ps2_data;
	joy_t        joystick_0;
	joy_t        joystick_1;
	logic [31:0] status;
	logic        button_reset;
	logic [7:0]  sample;
	video_in_t   video;
	controls_t   controls;
	logic        game_reset_n;
	logic        audio_bit;
	rgb_t        rgb;
	logic        vga_hs;
	logic        vga_vs;

	step_t       steps[$];
	logic [31:0] lcg_state = 32'd24979;
	int          cycle_cnt = 0;
	int          err_controls = 0;
	int          err_rgb = 0;
	int          err_count = 0;
	int          err_bit = 0;

	arcade_io_top #(
		.AUDIO_W     (8),
		.SYNC_STAGES (2)
	) arcade_io_top_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.button_reset (button_reset),
		.sample       (sample),
		.video        (video),
		.controls     (controls),
		.game_reset_n (game_reset_n),
		.audio_bit    (audio_bit),
		.rgb          (rgb),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////
	// checks
	////////////////////

	task automatic check_controls(input string what, input controls_t got, input controls_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			err_controls++;
		end
	endtask

	task automatic check_rgb(input string what, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			err_rgb++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp, input int tol);
		if (got < exp - tol || got > exp + tol) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			err_bit++;
		end
	endtask

	////////////////////
	// models and drivers
	////////////////////

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// a game input is low when the keyboard or either joystick presses it.
	function automatic controls_t expected_controls(input joy_t k, input joy_t j0, input joy_t j1,
			input logic test);
		joy_t      p;
		controls_t c;
		p = k | j0 | j1;
		c.up_n     = ~p.up;
		c.down_n   = ~p.down;
		c.left_n   = ~p.left;
		c.right_n  = ~p.right;
		c.fire_n   = ~p.fire;
		c.start1_n = ~p.start1;
		c.start2_n = ~p.start2;
		c.coin_n   = ~p.coin;
		c.test_n   = ~test;
		return c;
	endfunction

	task automatic add_step(input logic [1:0] n, input logic [2:0] bad, input logic [7:0] b0,
			input logic [7:0] b1, input logic [7:0] b2, input joy_t keys_exp, input joy_t j0,
			input joy_t j1, input logic [31:0] st, input logic btn);
		step_t s;
		s = '{n, bad, {b2, b1, b0}, keys_exp, j0, j1, st, btn};
		steps.push_back(s);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [10:0] frame;
		int          i;
		frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};  // stop, odd parity, data, start.
		repeat (PS2_HALF) @(negedge clk_sys);
		for (i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			repeat (PS2_HALF) @(negedge clk_sys);
			ps2_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk_sys);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic apply_step(input int idx, input step_t s);
		int        k;
		controls_t exp_ctl;
		logic      exp_rst;
		joystick_0   = s.j0;
		joystick_1   = s.j1;
		status       = s.status;
		button_reset = s.btn;
		for (k = 0; k < int'(s.n); k++) begin
			send_frame(s.bytes[8*k +: 8], s.bad[k]);
		end
		repeat (SETTLE) @(negedge clk_sys);
		exp_ctl = expected_controls(s.keys_exp, s.j0, s.j1, s.status[STATUS_TEST_BIT]);
		exp_rst = ~(s.status[STATUS_RESET_BIT] | s.status[STATUS_MENU_RESET_BIT] | s.btn);
		check_controls($sformatf("step %0d controls", idx), controls, exp_ctl);
		check_bit($sformatf("step %0d game_reset_n", idx), game_reset_n, exp_rst);
	endtask

	task automatic run_audio(input logic [7:0] value);
		int ones;
		int c;
		sample = value;
		ones = 0;
		for (c = 0; c < AUDIO_HOLD; c++) begin
			@(negedge clk_sys);
			if (c >= AUDIO_HOLD - AUDIO_WINDOW && audio_bit) begin
				ones++;
			end
		end
		check_count($sformatf("audio ones for sample %0d", value), ones, int'(value), 1);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int        i;
		video_in_t v;
		rst_n        = 1'b0;
		ps2_clk      = 1'b1;
		ps2_data     = 1'b1;
		joystick_0   = '0;
		joystick_1   = '0;
		status       = '0;
		button_reset = 1'b0;
		sample       = '0;
		video        = '0;

		// plain keys, then arrows behind E0, then bytes that must change nothing.
		add_step(2'd0, 3'b000, 8'h0, 8'h0, 8'h0, '0, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b000, SC_SPACE, 8'h0, 8'h0, K_F, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b000, SC_BREAK, SC_SPACE, 8'h0, '0, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b000, SC_EXT, SC_UP, 8'h0, K_U, '0, '0, 32'h0, 1'b0);
		add_step(2'd3, 3'b000, SC_EXT, SC_BREAK, SC_UP, '0, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b000, SC_EXT, SC_LEFT, 8'h0, K_L, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b000, SC_1, 8'h0, 8'h0, K_L | K_S1, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b000, SC_2, 8'h0, 8'h0, K_L | K_S1 | K_S2, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b000, SC_5, 8'h0, 8'h0, K_L | K_S1 | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b000, SC_BREAK, SC_1, 8'h0, K_L | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b000, SC_UP, 8'h0, 8'h0, K_L | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd3, 3'b010, SC_EXT, SC_RIGHT, SC_RIGHT, K_L | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd1, 3'b001, SC_SPACE, 8'h0, 8'h0, K_L | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b001, SC_BREAK, SC_5, 8'h0, K_L | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		add_step(2'd2, 3'b000, SC_EXT, SC_RIGHT, 8'h0, K_L | K_R | K_S2 | K_C, '0, '0, 32'h0, 1'b0);
		// joysticks, test switch and the three reset sources.
		add_step(2'd0, 3'b000, 8'h0, 8'h0, 8'h0, K_L | K_R | K_S2 | K_C, K_U, K_F, 32'h2, 1'b0);
		add_step(2'd0, 3'b000, 8'h0, 8'h0, 8'h0, K_L | K_R | K_S2 | K_C, '0, '0, 32'h1, 1'b0);
		add_step(2'd0, 3'b000, 8'h0, 8'h0, 8'h0, K_L | K_R | K_S2 | K_C, '0, '0, 32'h40, 1'b0);
		add_step(2'd0, 3'b000, 8'h0, 8'h0, 8'h0, K_L | K_R | K_S2 | K_C, '0, '0, 32'h0, 1'b1);
		add_step(2'd2, 3'b000, SC_BREAK, SC_2, 8'h0, K_L | K_R | K_C, K_C, K_D, 32'h0, 1'b0);
		add_step(2'd3, 3'b000, SC_EXT, SC_BREAK, SC_LEFT, K_R | K_C, '0, '0, 32'h0, 1'b0);

		repeat (15) @(negedge clk_sys);
		check_controls("controls in reset", controls, '1);
		check_bit("game_reset_n in reset", game_reset_n, 1'b0);
		check_bit("audio_bit in reset", audio_bit, 1'b0);
		check_rgb("rgb in reset", rgb, '0);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_bit("game_reset_n one cycle after reset", game_reset_n, 1'b0);
		@(negedge clk_sys);
		check_bit("game_reset_n released", game_reset_n, 1'b1);

		for (i = 0; i < steps.size(); i++) begin
			apply_step(i, steps[i]);
		end

		for (i = 0; i < AUDIO_RUNS; i++) begin
			run_audio(next_random());
		end

		// every pixel, sync and blanking combination.
		for (i = 0; i < 32; i++) begin
			v = video_in_t'(i[4:0]);
			video = v;
			@(negedge clk_sys);
			check_rgb($sformatf("rgb for video %b", v), rgb, (v.pixel & ~v.hb & ~v.vb) ? '1 : '0);
			check_bit($sformatf("vga_hs for video %b", v), vga_hs, v.hs);
			check_bit($sformatf("vga_vs for video %b", v), vga_vs, v.vs);
		end

		$display("errors: controls %0d, rgb %0d, count %0d, bit %0d",
			err_controls, err_rgb, err_count, err_bit);
		if (err_controls + err_rgb + err_count + err_bit == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== arcade_io.f ====
rtl/arcade_io_pkg.sv
rtl/ps2_receiver.sv
rtl/key_mapper.sv
rtl/control_merge.sv
rtl/audio_dac.sv
rtl/mono_video_out.sv
rtl/arcade_io_top.sv
verif/arcade_io_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= arcade_io.f
TB_TOP    ?= arcade_io_tb
RTL_TOP   ?= arcade_io_top
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Simulation PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

# the status of the recipe is that of grep, so a missing pass line fails the target.
sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
